// File: Bender.yml
package:
  name: lsu_issue

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_lzp.sv
      - lsu_lu_buffer.sv
      - lsu_su_fifo.sv
      - lsu_regfile.sv
      - lsu_issue.sv
      - lsu_issue_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - lsu_issue_checker.sv
      - lsu_issue_tb.sv

// File: lsu_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU issue configuration
// Data width, register and queue sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Integer data width
`define LSU_XLEN 64

// Architectural integer registers
`define LSU_ARCH_REGS 32

// Rename bits per architectural register
`define LSU_RB 2

// Queue depths
`define LSU_LU_DEPTH 8
`define LSU_SU_DEPTH 4

// Derived sizes, physical registers and read ports (loads plus rs1/rs2 of store)
`define LSU_PHYS_REGS (`LSU_ARCH_REGS << `LSU_RB)
`define LSU_RD_PORTS (`LSU_LU_DEPTH + 2)

`endif

// File: lsu_issue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store issue selection
// Operand read, address add and
// registered execute parameters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_issue (
	input logic CLK,
	input logic arst_n,
	input logic flush,
	input logic [`LSU_LU_DEPTH-1:0] lu_malloc,
	input lsu_pkg::lu_issue_t [`LSU_LU_DEPTH-1:0] lu_slots,
	output logic lu_pop,
	output lsu_pkg::lu_idx_t lu_pop_index,
	input logic lu_exe_ready,
	output logic lu_exe_valid,
	output lsu_pkg::lu_exe_t lu_exe,
	input logic su_empty,
	input lsu_pkg::su_issue_t su_head,
	output logic su_pop,
	input logic su_exe_ready,
	input logic su_ilp_ready,
	output logic su_exe_valid,
	output lsu_pkg::su_exe_t su_exe,
	output lsu_pkg::phys_tag_t [`LSU_RD_PORTS-1:0] rd_tag,
	input lsu_pkg::xdata_t [`LSU_RD_PORTS-1:0] rd_data,
	input logic [`LSU_PHYS_REGS-1:0] wb_log
);

	import lsu_pkg::*;

	// Store read ports sit after the load slots
	localparam int SR1 = `LSU_LU_DEPTH;
	localparam int SR2 = `LSU_LU_DEPTH + 1;

	logic [`LSU_LU_DEPTH-1:0] lu_rdy;
	lu_exe_t [`LSU_LU_DEPTH-1:0] lu_cand;
	logic lu_none;
	logic lu_issue;
	logic su_rs1_rdy;
	logic su_rs2_rdy;
	logic su_go;
	logic su_issue;
	su_exe_t su_cand;

	// Per-slot decode
	always_comb begin
		for (int i = 0; i < `LSU_LU_DEPTH; i++) begin
			rd_tag[i] = lu_slots[i].rs1;
			// Source written, or x0
			lu_rdy[i] = lu_malloc[i]
				& (wb_log[lu_slots[i].rs1] | tag_is_x0(lu_slots[i].rs1));
			// Signed and unsigned forms share a size flag
			lu_cand[i].b = lu_slots[i].lb | lu_slots[i].lbu;
			lu_cand[i].h = lu_slots[i].lh | lu_slots[i].lhu;
			lu_cand[i].w = lu_slots[i].lw | lu_slots[i].lwu;
			lu_cand[i].d = lu_slots[i].ld;
			lu_cand[i].rd0 = lu_slots[i].rd0;
			lu_cand[i].addr = rd_data[i] + lu_slots[i].imm;
			lu_cand[i].usi = lu_slots[i].lbu | lu_slots[i].lhu | lu_slots[i].lwu;
		end
		rd_tag[SR1] = su_head.rs1;
		rd_tag[SR2] = su_head.rs2;
	end

	// Lowest ready slot
	lsu_lzp #(
		.CW($bits(lu_idx_t))
	) u_lu_sel (
		.in(~lu_rdy),
		.pos(lu_pop_index),
		.all_one(lu_none)
	);

	// Slot leaves on the edge that loads the execute register
	assign lu_issue = lu_exe_ready & ~lu_none & ~flush;
	assign lu_pop = lu_issue;

	// Valid holds while the load unit stalls
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			lu_exe_valid <= 1'b0;
		end else if (flush) begin
			lu_exe_valid <= 1'b0;
		end else if (lu_exe_ready) begin
			lu_exe_valid <= ~lu_none;
		end
	end

	always_ff @(posedge CLK) begin
		if (flush) begin
			lu_exe <= '0;
		end else if (lu_issue) begin
			lu_exe <= lu_cand[lu_pop_index];
		end
	end

	// Head store only, both sources needed
	assign su_rs1_rdy = wb_log[su_head.rs1] | tag_is_x0(su_head.rs1);
	assign su_rs2_rdy = wb_log[su_head.rs2] | tag_is_x0(su_head.rs2);

	// Commit must call the store non-speculative
	assign su_go = ~su_empty & su_rs1_rdy & su_rs2_rdy & su_ilp_ready;
	assign su_issue = su_exe_ready & su_go & ~flush;
	assign su_pop = su_issue;

	always_comb begin
		su_cand.sb = su_head.sb;
		su_cand.sh = su_head.sh;
		su_cand.sw = su_head.sw;
		su_cand.sd = su_head.sd;
		su_cand.addr = rd_data[SR1] + su_head.imm;
		su_cand.data = rd_data[SR2];
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			su_exe_valid <= 1'b0;
		end else if (flush) begin
			su_exe_valid <= 1'b0;
		end else if (su_exe_ready) begin
			su_exe_valid <= su_go;
		end
	end

	// Payload keeps its last value between stores
	always_ff @(posedge CLK) begin
		if (flush) begin
			su_exe <= '0;
		end else if (su_issue) begin
			su_exe <= su_cand;
		end
	end

endmodule

// File: lsu_issue_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU issue protocol checker
// Reset, back-pressure and flush rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lsu_issue_checker (
	input logic CLK,
	input logic arst_n,
	input logic flush,
	input logic lu_exe_ready,
	input logic lu_exe_valid,
	input lsu_pkg::lu_exe_t lu_exe,
	input logic lu_pop,
	input logic su_exe_ready,
	input logic su_exe_valid,
	input lsu_pkg::su_exe_t su_exe,
	input logic su_pop
);

	// Failed assertions so far
	int fail_count = 0;

	// Control outputs low while in reset
	reset_quiet: assert property (@(posedge CLK)
		!arst_n |-> !lu_exe_valid && !su_exe_valid && !lu_pop && !su_pop)
		else begin
			fail_count++;
			$error("control output high during reset");
		end

	// First edge after release still idle
	reset_release: assert property (@(posedge CLK)
		$rose(arst_n) |-> !lu_exe_valid && !su_exe_valid)
		else begin
			fail_count++;
			$error("execute valid high right after reset release");
		end

	// Stalled load keeps valid and payload
	lu_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		lu_exe_valid && !lu_exe_ready && !flush |=> lu_exe_valid && $stable(lu_exe))
		else begin
			fail_count++;
			$error("load execute output changed under back-pressure");
		end

	// Same for the store side
	su_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		su_exe_valid && !su_exe_ready && !flush |=> su_exe_valid && $stable(su_exe))
		else begin
			fail_count++;
			$error("store execute output changed under back-pressure");
		end

	// Flush kills both outputs on the next edge
	flush_clear: assert property (@(posedge CLK) disable iff (!arst_n)
		flush |=> !lu_exe_valid && !su_exe_valid)
		else begin
			fail_count++;
			$error("flush did not clear the execute outputs");
		end

endmodule

// File: lsu_issue_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU issue stage testbench
// Directed load/store issue tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_issue_tb;

	import lsu_pkg::*;

	// Whole run is under 250 cycles
	localparam int MAX_CYCLES = 400;
	localparam int WAIT_LIMIT = 20;

	// Load and store kinds
	localparam int LB = 0;
	localparam int LH = 1;
	localparam int LW = 2;
	localparam int LD = 3;
	localparam int LBU = 4;
	localparam int LHU = 5;
	localparam int LWU = 6;
	localparam int SB = 0;
	localparam int SH = 1;
	localparam int SW = 2;
	localparam int SD = 3;

	logic CLK;
	logic arst_n;
	logic flush;
	logic lu_dispatch;
	lu_issue_t lu_dispatch_info;
	logic lu_full;
	logic su_dispatch;
	su_issue_t su_dispatch_info;
	logic su_full;
	logic wb_valid;
	phys_tag_t wb_tag;
	xdata_t wb_data;
	logic lu_exe_ready;
	logic lu_exe_valid;
	lu_exe_t lu_exe;
	logic su_exe_ready;
	logic su_ilp_ready;
	logic su_exe_valid;
	su_exe_t su_exe;

	integer seed;
	int cycle_count = 0;
	int test_errs;
	int total_errs;
	int tests_run;
	int tests_bad;
	string test_name;
	// Expected register contents
	xdata_t model [`LSU_PHYS_REGS];

	lsu_issue_top DUT (.*);

	bind lsu_issue_top lsu_issue_checker u_checker (
		.CLK(CLK), .arst_n(arst_n), .flush(flush),
		.lu_exe_ready(lu_exe_ready), .lu_exe_valid(lu_exe_valid), .lu_exe(lu_exe),
		.lu_pop(lu_pop),
		.su_exe_ready(su_exe_ready), .su_exe_valid(su_exe_valid), .su_exe(su_exe),
		.su_pop(su_pop)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Run limit
	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Arch index in the upper five bits
	function automatic phys_tag_t make_tag(input int arch, input int copy);
		return {arch[4:0], copy[`LSU_RB-1:0]};
	endfunction

	// Any copy of x0 reads zero
	function automatic xdata_t reg_value(input phys_tag_t t);
		if (t[`LSU_RB +: 5] == 5'd0) begin
			return '0;
		end
		return model[t];
	endfunction

	function automatic xdata_t rand64();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("Test %s: ok", test_name);
		end else begin
			tests_bad++;
			$display("Test %s: %0d check(s) failed", test_name, test_errs);
		end
	endtask

	task automatic check(input string what, input xdata_t exp, input xdata_t act);
		assert (act === exp) else begin
			$display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic note_error(input string msg);
		$display("Error in %s: %s", test_name, msg);
		test_errs++;
	endtask

	task automatic writeback(input phys_tag_t t, input xdata_t d);
		@(posedge CLK);
		wb_valid <= 1'b1;
		wb_tag <= t;
		wb_data <= d;
		model[t] = d;
		@(posedge CLK);
		wb_valid <= 1'b0;
	endtask

	task automatic dispatch_load(input int kind, input xdata_t imm, input phys_tag_t rd0,
			input phys_tag_t rs1);
		lu_issue_t op;
		op = '0;
		case (kind)
			LB: op.lb = 1'b1;
			LH: op.lh = 1'b1;
			LW: op.lw = 1'b1;
			LD: op.ld = 1'b1;
			LBU: op.lbu = 1'b1;
			LHU: op.lhu = 1'b1;
			default: op.lwu = 1'b1;
		endcase
		op.imm = imm;
		op.rd0 = rd0;
		op.rs1 = rs1;
		@(posedge CLK);
		lu_dispatch <= 1'b1;
		lu_dispatch_info <= op;
		@(posedge CLK);
		lu_dispatch <= 1'b0;
	endtask

	task automatic dispatch_store(input int kind, input xdata_t imm, input phys_tag_t rs1,
			input phys_tag_t rs2);
		su_issue_t op;
		op = '0;
		case (kind)
			SB: op.sb = 1'b1;
			SH: op.sh = 1'b1;
			SW: op.sw = 1'b1;
			default: op.sd = 1'b1;
		endcase
		op.imm = imm;
		op.rs1 = rs1;
		op.rs2 = rs2;
		@(posedge CLK);
		su_dispatch <= 1'b1;
		su_dispatch_info <= op;
		@(posedge CLK);
		su_dispatch <= 1'b0;
	endtask

	// Next load on the execute port with the address from the model
	task automatic expect_load(input int kind, input phys_tag_t rs1, input xdata_t imm,
			input phys_tag_t rd0);
		int n;
		logic [3:0] size;
		n = 0;
		size = {kind == LB || kind == LBU, kind == LH || kind == LHU,
			kind == LW || kind == LWU, kind == LD};
		@(negedge CLK);
		while (!lu_exe_valid && n < WAIT_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (!lu_exe_valid) begin
			note_error("load did not reach the execute port in time");
		end else begin
			check("load addr", reg_value(rs1) + imm, lu_exe.addr);
			check("load size", size, {lu_exe.b, lu_exe.h, lu_exe.w, lu_exe.d});
			check("load unsigned", kind >= LBU, lu_exe.usi);
			check("load rd0", rd0, lu_exe.rd0);
		end
	endtask

	task automatic expect_store(input int kind, input xdata_t imm, input phys_tag_t rs1,
			input phys_tag_t rs2);
		int n;
		n = 0;
		@(negedge CLK);
		while (!su_exe_valid && n < WAIT_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (!su_exe_valid) begin
			note_error("store did not reach the execute port in time");
		end else begin
			check("store addr", reg_value(rs1) + imm, su_exe.addr);
			check("store data", reg_value(rs2), su_exe.data);
			check("store size", 4'b1000 >> kind, {su_exe.sb, su_exe.sh, su_exe.sw, su_exe.sd});
		end
	endtask

	// Nothing may issue for a while
	task automatic expect_quiet(input int n);
		repeat (n) begin
			@(negedge CLK);
			assert (!lu_exe_valid && !su_exe_valid)
				else note_error("execute valid raised with nothing issuable");
		end
	endtask

	initial begin
		phys_tag_t ra;
		phys_tag_t rb;
		phys_tag_t rc;
		phys_tag_t tp;
		phys_tag_t tq;
		int asrt_errs;
		seed = 73202;
		tests_run = 0;
		tests_bad = 0;
		total_errs = 0;
		arst_n = 1'b0;
		flush = 1'b0;
		lu_dispatch = 1'b0;
		lu_dispatch_info = '0;
		su_dispatch = 1'b0;
		su_dispatch_info = '0;
		wb_valid = 1'b0;
		wb_tag = '0;
		wb_data = '0;
		lu_exe_ready = 1'b0;
		su_exe_ready = 1'b0;
		su_ilp_ready = 1'b0;
		repeat (5) @(posedge CLK);
		arst_n <= 1'b1;
		lu_exe_ready <= 1'b1;
		su_exe_ready <= 1'b1;
		ra = make_tag(5, 0);
		rb = make_tag(8, 0);
		rc = make_tag(9, 0);
		tp = make_tag(7, 1);
		tq = make_tag(11, 1);

		// Every load kind from one base register
		begin_test("load_sizes");
		writeback(ra, rand64());
		for (int k = 0; k < 7; k++) begin
			dispatch_load(k, 64'h10 * k + 64'h3, make_tag(20 + k, 0), ra);
			expect_load(k, ra, 64'h10 * k + 64'h3, make_tag(20 + k, 0));
		end
		end_test();

		// Pending source waits while a younger ready load overtakes
		begin_test("load_ooo");
		@(posedge CLK);
		lu_exe_ready <= 1'b0;
		dispatch_load(LW, 64'h40, tp, make_tag(0, 2));
		// This load claims the x0 copy that the first load reads
		dispatch_load(LD, 64'h8, make_tag(0, 2), tp);
		dispatch_load(LBU, 64'h10, make_tag(22, 1), ra);
		lu_exe_ready <= 1'b1;
		expect_load(LW, make_tag(0, 2), 64'h40, tp);
		expect_load(LBU, ra, 64'h10, make_tag(22, 1));
		expect_quiet(4);
		writeback(tp, rand64());
		expect_load(LD, tp, 64'h8, make_tag(0, 2));
		end_test();

		// In-order stores gated by commit and by a pending rs2
		begin_test("store_order");
		writeback(rb, rand64());
		writeback(rc, rand64());
		// This load claims tq and leaves it unwritten
		dispatch_load(LD, 64'h0, tq, make_tag(0, 1));
		expect_load(LD, make_tag(0, 1), 64'h0, tq);
		dispatch_store(SW, 64'h20, ra, rb);
		dispatch_store(SD, 64'h30, rb, tq);
		dispatch_store(SB, 64'h7, make_tag(0, 3), rc);
		expect_quiet(6);
		@(posedge CLK);
		su_ilp_ready <= 1'b1;
		expect_store(SW, 64'h20, ra, rb);
		expect_quiet(5);
		writeback(tq, rand64());
		expect_store(SD, 64'h30, rb, tq);
		expect_store(SB, 64'h7, make_tag(0, 3), rc);
		end_test();

		// One accepted item each before the unit stalls
		begin_test("back_pressure");
		@(posedge CLK);
		lu_exe_ready <= 1'b0;
		su_exe_ready <= 1'b0;
		dispatch_load(LW, 64'h50, make_tag(24, 0), ra);
		dispatch_load(LH, 64'h60, make_tag(25, 0), rb);
		lu_exe_ready <= 1'b1;
		@(posedge CLK);
		lu_exe_ready <= 1'b0;
		repeat (4) begin
			@(negedge CLK);
			check("held load valid", 1'b1, lu_exe_valid);
			check("held load addr", reg_value(ra) + 64'h50, lu_exe.addr);
		end
		@(posedge CLK);
		lu_exe_ready <= 1'b1;
		// Held load is taken at this edge
		@(posedge CLK);
		expect_load(LH, rb, 64'h60, make_tag(25, 0));
		dispatch_store(SH, 64'h80, ra, rc);
		dispatch_store(SD, 64'h90, rc, ra);
		su_exe_ready <= 1'b1;
		@(posedge CLK);
		su_exe_ready <= 1'b0;
		repeat (4) begin
			@(negedge CLK);
			check("held store valid", 1'b1, su_exe_valid);
			check("held store addr", reg_value(ra) + 64'h80, su_exe.addr);
			check("held store data", reg_value(rc), su_exe.data);
		end
		@(posedge CLK);
		su_exe_ready <= 1'b1;
		@(posedge CLK);
		expect_store(SD, 64'h90, rc, ra);
		end_test();

		// Flush with both outputs valid and both queues occupied
		begin_test("flush");
		@(posedge CLK);
		lu_exe_ready <= 1'b0;
		su_exe_ready <= 1'b0;
		dispatch_load(LB, 64'h1, make_tag(26, 0), ra);
		dispatch_load(LD, 64'h2, make_tag(27, 0), rb);
		dispatch_store(SW, 64'h3, ra, rb);
		dispatch_store(SW, 64'h4, rb, ra);
		lu_exe_ready <= 1'b1;
		su_exe_ready <= 1'b1;
		@(posedge CLK);
		lu_exe_ready <= 1'b0;
		su_exe_ready <= 1'b0;
		flush <= 1'b1;
		@(negedge CLK);
		check("load valid before flush", 1'b1, lu_exe_valid);
		check("store valid before flush", 1'b1, su_exe_valid);
		@(posedge CLK);
		flush <= 1'b0;
		@(negedge CLK);
		check("load valid after flush", 1'b0, lu_exe_valid);
		check("store valid after flush", 1'b0, su_exe_valid);
		@(posedge CLK);
		lu_exe_ready <= 1'b1;
		su_exe_ready <= 1'b1;
		expect_quiet(5);
		dispatch_load(LWU, 64'h44, make_tag(28, 0), ra);
		expect_load(LWU, ra, 64'h44, make_tag(28, 0));
		end_test();

		// Reset in the middle of traffic
		begin_test("reset");
		@(posedge CLK);
		lu_exe_ready <= 1'b0;
		su_exe_ready <= 1'b0;
		// Second load and store stay queued across reset
		dispatch_load(LW, 64'h5, make_tag(29, 0), ra);
		dispatch_load(LH, 64'h7, make_tag(30, 0), rb);
		dispatch_store(SD, 64'h6, ra, rb);
		dispatch_store(SB, 64'h8, rb, ra);
		lu_exe_ready <= 1'b1;
		su_exe_ready <= 1'b1;
		@(posedge CLK);
		lu_exe_ready <= 1'b0;
		su_exe_ready <= 1'b0;
		@(posedge CLK);
		arst_n <= 1'b0;
		@(negedge CLK);
		check("load valid in reset", 1'b0, lu_exe_valid);
		check("store valid in reset", 1'b0, su_exe_valid);
		check("load full in reset", 1'b0, lu_full);
		check("store full in reset", 1'b0, su_full);
		repeat (5) @(posedge CLK);
		arst_n <= 1'b1;
		lu_exe_ready <= 1'b1;
		su_exe_ready <= 1'b1;
		expect_quiet(4);
		end_test();

		repeat (2) @(posedge CLK);
		asrt_errs = DUT.u_checker.fail_count;
		$display("Summary: %0d tests run, %0d failed, %0d failed checks, %0d failed assertions",
			tests_run, tests_bad, total_errs, asrt_errs);
		if (total_errs == 0 && asrt_errs == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: lsu_issue_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU issue stage top level
// Buffers, register file and issue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_issue_top (
	input logic CLK,
	input logic arst_n,
	input logic flush,
	input logic lu_dispatch,
	input lsu_pkg::lu_issue_t lu_dispatch_info,
	output logic lu_full,
	input logic su_dispatch,
	input lsu_pkg::su_issue_t su_dispatch_info,
	output logic su_full,
	input logic wb_valid,
	input lsu_pkg::phys_tag_t wb_tag,
	input lsu_pkg::xdata_t wb_data,
	input logic lu_exe_ready,
	output logic lu_exe_valid,
	output lsu_pkg::lu_exe_t lu_exe,
	input logic su_exe_ready,
	input logic su_ilp_ready,
	output logic su_exe_valid,
	output lsu_pkg::su_exe_t su_exe
);

	import lsu_pkg::*;

	logic [`LSU_LU_DEPTH-1:0] lu_malloc;
	lu_issue_t [`LSU_LU_DEPTH-1:0] lu_slots;
	logic lu_pop;
	lu_idx_t lu_pop_index;
	logic su_pop;
	logic su_empty;
	su_issue_t su_head;
	logic alloc_valid;
	phys_tag_t [`LSU_RD_PORTS-1:0] rd_tag;
	xdata_t [`LSU_RD_PORTS-1:0] rd_data;
	logic [`LSU_PHYS_REGS-1:0] wb_log;

	// Accepted load claims its destination tag
	assign alloc_valid = lu_dispatch & ~lu_full;

	lsu_lu_buffer u_lu_buffer (
		.CLK(CLK), .arst_n(arst_n), .flush(flush),
		.lu_dispatch(lu_dispatch), .lu_dispatch_info(lu_dispatch_info),
		.lu_full(lu_full), .lu_pop(lu_pop), .lu_pop_index(lu_pop_index),
		.lu_malloc(lu_malloc), .lu_slots(lu_slots)
	);

	lsu_su_fifo u_su_fifo (
		.CLK(CLK), .arst_n(arst_n), .flush(flush),
		.su_dispatch(su_dispatch), .su_dispatch_info(su_dispatch_info),
		.su_full(su_full), .su_pop(su_pop), .su_empty(su_empty), .su_head(su_head)
	);

	lsu_regfile u_regfile (
		.CLK(CLK), .arst_n(arst_n),
		.wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data),
		.alloc_valid(alloc_valid), .alloc_tag(lu_dispatch_info.rd0),
		.rd_tag(rd_tag), .rd_data(rd_data), .wb_log(wb_log)
	);

	lsu_issue u_issue (
		.CLK(CLK), .arst_n(arst_n), .flush(flush),
		.lu_malloc(lu_malloc), .lu_slots(lu_slots),
		.lu_pop(lu_pop), .lu_pop_index(lu_pop_index),
		.lu_exe_ready(lu_exe_ready), .lu_exe_valid(lu_exe_valid), .lu_exe(lu_exe),
		.su_empty(su_empty), .su_head(su_head), .su_pop(su_pop),
		.su_exe_ready(su_exe_ready), .su_ilp_ready(su_ilp_ready),
		.su_exe_valid(su_exe_valid), .su_exe(su_exe),
		.rd_tag(rd_tag), .rd_data(rd_data), .wb_log(wb_log)
	);

endmodule

// File: lsu_lu_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load issue buffer
// Slot array, lowest-free allocation,
// removal by index in any order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_lu_buffer (
	input logic CLK,
	input logic arst_n,
	input logic flush,
	input logic lu_dispatch,
	input lsu_pkg::lu_issue_t lu_dispatch_info,
	output logic lu_full,
	input logic lu_pop,
	input lsu_pkg::lu_idx_t lu_pop_index,
	output logic [`LSU_LU_DEPTH-1:0] lu_malloc,
	output lsu_pkg::lu_issue_t [`LSU_LU_DEPTH-1:0] lu_slots
);

	import lsu_pkg::*;

	lu_idx_t free_idx;
	logic push;
	logic [`LSU_LU_DEPTH-1:0] malloc_nxt;

	// Dispatch into a full buffer is dropped
	assign lu_full = &lu_malloc;
	assign push = lu_dispatch & ~lu_full;

	// Lowest free slot
	always_comb begin
		free_idx = '0;
		for (int i = `LSU_LU_DEPTH - 1; i >= 0; i--) begin
			if (!lu_malloc[i]) begin
				free_idx = lu_idx_t'(i);
			end
		end
	end

	// Popped slot is still valid this cycle, so it never equals free_idx
	always_comb begin
		malloc_nxt = lu_malloc;
		if (lu_pop) begin
			malloc_nxt[lu_pop_index] = 1'b0;
		end
		if (push) begin
			malloc_nxt[free_idx] = 1'b1;
		end
		// Flush beats dispatch and pop
		if (flush) begin
			malloc_nxt = '0;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			lu_malloc <= '0;
		end else begin
			lu_malloc <= malloc_nxt;
		end
	end

	// Slot payload, only meaningful under its valid bit
	always_ff @(posedge CLK) begin
		if (push && !flush) begin
			lu_slots[free_idx] <= lu_dispatch_info;
		end
	end

endmodule

// File: lsu_lzp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lowest zero position
// Priority encode the first clear bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_lzp #(
	parameter int CW = $clog2(`LSU_LU_DEPTH)
) (
	input logic [`LSU_LU_DEPTH-1:0] in,
	output logic [CW-1:0] pos,
	output logic all_one
);

	// Scan high to low so the lowest clear bit is the last write
	always_comb begin
		pos = '0;
		for (int i = `LSU_LU_DEPTH - 1; i >= 0; i--) begin
			if (!in[i]) begin
				pos = CW'(i);
			end
		end
	end

	// No clear bit at all, pos is then meaningless
	assign all_one = &in;

endmodule

// File: lsu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU issue types
// Micro-op and execute records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lsu_config.svh"

package lsu_pkg;

	// Tag is arch index in upper five bits, rename copy below
	typedef logic [5+`LSU_RB-1:0] phys_tag_t;
	typedef logic [`LSU_XLEN-1:0] xdata_t;
	typedef logic [$clog2(`LSU_LU_DEPTH)-1:0] lu_idx_t;

	// Load micro-op, size flags one-hot
	typedef struct packed {
		logic lb;
		logic lh;
		logic lw;
		logic ld;
		logic lbu;
		logic lhu;
		logic lwu;
		xdata_t imm;
		phys_tag_t rd0;
		phys_tag_t rs1;
	} lu_issue_t;

	// Store micro-op
	typedef struct packed {
		logic sb;
		logic sh;
		logic sw;
		logic sd;
		xdata_t imm;
		phys_tag_t rs1;
		phys_tag_t rs2;
	} su_issue_t;

	// Load execute parameter, signedness folded into usi
	typedef struct packed {
		logic b;
		logic h;
		logic w;
		logic d;
		phys_tag_t rd0;
		xdata_t addr;
		logic usi;
	} lu_exe_t;

	// Store execute parameter
	typedef struct packed {
		logic sb;
		logic sh;
		logic sw;
		logic sd;
		xdata_t addr;
		xdata_t data;
	} su_exe_t;

	// Any rename copy of x0
	function automatic logic tag_is_x0(phys_tag_t tag);
		return tag[`LSU_RB +: 5] == 5'd0;
	endfunction

endpackage

// File: lsu_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Physical register file
// One writeback port, combinational
// read ports and the writeback log
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_regfile (
	input logic CLK,
	input logic arst_n,
	input logic wb_valid,
	input lsu_pkg::phys_tag_t wb_tag,
	input lsu_pkg::xdata_t wb_data,
	input logic alloc_valid,
	input lsu_pkg::phys_tag_t alloc_tag,
	input lsu_pkg::phys_tag_t [`LSU_RD_PORTS-1:0] rd_tag,
	output lsu_pkg::xdata_t [`LSU_RD_PORTS-1:0] rd_data,
	output logic [`LSU_PHYS_REGS-1:0] wb_log
);

	import lsu_pkg::*;

	xdata_t regs [`LSU_PHYS_REGS];

	// Writes to x0 copies are dropped
	always_ff @(posedge CLK) begin
		if (wb_valid && !tag_is_x0(wb_tag)) begin
			regs[wb_tag] <= wb_data;
		end
	end

	// Read ports, x0 forced to zero
	always_comb begin
		for (int i = 0; i < `LSU_RD_PORTS; i++) begin
			if (tag_is_x0(rd_tag[i])) begin
				rd_data[i] = '0;
			end else begin
				rd_data[i] = regs[rd_tag[i]];
			end
		end
	end

	// Writeback log
	// Set on writeback, cleared when a new producer claims the tag
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			// Every register counts as written out of reset
			wb_log <= '1;
		end else begin
			if (wb_valid) begin
				wb_log[wb_tag] <= 1'b1;
			end
			// Later assignment, so allocation wins on the same tag
			if (alloc_valid) begin
				wb_log[alloc_tag] <= 1'b0;
			end
		end
	end

endmodule

// File: lsu_su_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store issue FIFO
// Keeps stores in program order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_su_fifo (
	input logic CLK,
	input logic arst_n,
	input logic flush,
	input logic su_dispatch,
	input lsu_pkg::su_issue_t su_dispatch_info,
	output logic su_full,
	input logic su_pop,
	output logic su_empty,
	output lsu_pkg::su_issue_t su_head
);

	import lsu_pkg::*;

	localparam int PW = $clog2(`LSU_SU_DEPTH);

	su_issue_t mem [`LSU_SU_DEPTH];
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] wr_ptr;
	logic [PW:0] count;
	logic push;
	logic pop;

	assign su_empty = (count == '0);
	assign su_full = (count == (PW+1)'(`LSU_SU_DEPTH));
	assign push = su_dispatch & ~su_full;
	assign pop = su_pop & ~su_empty;
	assign su_head = mem[rd_ptr];

	// Pointers and occupancy, flush drops everything
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PW'(`LSU_SU_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PW'(`LSU_SU_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leaves count unchanged
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge CLK) begin
		if (push && !flush) begin
			mem[wr_ptr] <= su_dispatch_info;
		end
	end

endmodule

// File: sim.f
+incdir+.
lsu_pkg.sv
lsu_lzp.sv
lsu_lu_buffer.sv
lsu_su_fifo.sv
lsu_regfile.sv
lsu_issue.sv
lsu_issue_top.sv
lsu_issue_checker.sv
lsu_issue_tb.sv
